/* verilog/issue_pkg.sv */
package issue_pkg;

  localparam int data_width = 32;
  localparam int half_width = 16;  // Multiplier partial product split
  localparam int tag_width = 6;
  localparam int num_regs = 64;
  localparam int rob_width = 4;
  localparam int op_width = 4;
  localparam int imm_width = 16;
  localparam int num_entries = 3;
  localparam int entry_idx_width = 2;

  localparam logic [tag_width-1:0] zero_tag = '0;  // Never renamed to and reads as zero

  // Bit 3 selects the immediate form
  localparam logic [op_width-1:0] op_add = 4'd0;
  localparam logic [op_width-1:0] op_sub = 4'd1;
  localparam logic [op_width-1:0] op_and = 4'd2;
  localparam logic [op_width-1:0] op_xor = 4'd3;
  localparam logic [op_width-1:0] op_mul = 4'd4;
  localparam logic [op_width-1:0] op_addi = 4'd8;
  localparam logic [op_width-1:0] op_xori = 4'd9;
  localparam logic [op_width-1:0] op_muli = 4'd12;

  localparam logic unit_alu = 1'b0;
  localparam logic unit_mult = 1'b1;

  // Station type per entry with bit i for entry i
  localparam logic [num_entries-1:0] entry_unit = {unit_mult, unit_alu, unit_alu};

  typedef union packed {
    struct packed {
      logic [op_width-1:0] op;
      logic [tag_width-1:0] dest;
      logic [tag_width-1:0] src1;
      logic [tag_width-1:0] src2;
      logic [9:0] unused;
    } reg_form;
    struct packed {
      logic [op_width-1:0] op;
      logic [tag_width-1:0] dest;
      logic [tag_width-1:0] src1;
      logic [imm_width-1:0] imm;
    } imm_form;
  } dispatch_word_u;

endpackage

/* verilog/reservation_station.sv */
`timescale 1ns/1ps

module reservation_station (
  input  logic clock,
  input  logic reset,
  input  logic dispatch_req,
  input  issue_pkg::dispatch_word_u dispatch_word,
  input  logic [issue_pkg::rob_width-1:0] dispatch_rob,
  output logic dispatch_ack,
  output logic [issue_pkg::tag_width-1:0] src1_tag,
  output logic [issue_pkg::tag_width-1:0] src2_tag,
  input  logic src1_ready,
  input  logic [issue_pkg::data_width-1:0] src1_value,
  input  logic src2_ready,
  input  logic [issue_pkg::data_width-1:0] src2_value,
  output logic alloc_en,
  output logic [issue_pkg::tag_width-1:0] alloc_tag,
  input  logic cdb_valid,
  input  logic [issue_pkg::tag_width-1:0] cdb_tag,
  input  logic [issue_pkg::data_width-1:0] cdb_value,
  input  logic rollback_en,
  input  logic [issue_pkg::rob_width-1:0] rollback_rob,
  input  logic [issue_pkg::rob_width-1:0] rollback_count,
  input  logic [issue_pkg::num_entries-1:0] unit_ready,
  output logic [issue_pkg::num_entries-1:0] issue_valid,
  output logic [issue_pkg::num_entries-1:0][issue_pkg::op_width-1:0] issue_op,
  output logic [issue_pkg::num_entries-1:0][issue_pkg::data_width-1:0] issue_a,
  output logic [issue_pkg::num_entries-1:0][issue_pkg::data_width-1:0] issue_b,
  output logic [issue_pkg::num_entries-1:0][issue_pkg::tag_width-1:0] issue_tag,
  output logic [issue_pkg::num_entries-1:0][issue_pkg::rob_width-1:0] issue_rob
);

  logic [issue_pkg::num_entries-1:0] busy;
  logic [issue_pkg::num_entries-1:0][issue_pkg::op_width-1:0] op_q;
  logic [issue_pkg::num_entries-1:0][issue_pkg::tag_width-1:0] dest_q;
  logic [issue_pkg::num_entries-1:0][issue_pkg::rob_width-1:0] rob_q;
  logic [issue_pkg::num_entries-1:0][issue_pkg::tag_width-1:0] tag1_q;
  logic [issue_pkg::num_entries-1:0][issue_pkg::tag_width-1:0] tag2_q;
  logic [issue_pkg::num_entries-1:0] ready1_q;
  logic [issue_pkg::num_entries-1:0] ready2_q;
  logic [issue_pkg::num_entries-1:0][issue_pkg::data_width-1:0] value1_q;
  logic [issue_pkg::num_entries-1:0][issue_pkg::data_width-1:0] value2_q;
  logic [issue_pkg::num_entries-1:0] hit1;  // Bus carries operand 1 now
  logic [issue_pkg::num_entries-1:0] hit2;
  logic [issue_pkg::num_entries-1:0] ready1;
  logic [issue_pkg::num_entries-1:0] ready2;
  logic [issue_pkg::num_entries-1:0][issue_pkg::rob_width-1:0] rob_diff;
  logic [issue_pkg::num_entries-1:0] rolled;
  logic is_imm;
  logic is_mult;
  logic found;
  logic [issue_pkg::entry_idx_width-1:0] free_idx;
  logic accept;
  logic [issue_pkg::data_width-1:0] imm_value;
  logic op2_ready;
  logic [issue_pkg::data_width-1:0] op2_value;

  assign src1_tag = dispatch_word.reg_form.src1;
  assign src2_tag = dispatch_word.reg_form.src2;  // Ignored for the immediate form

  assign is_imm = dispatch_word.imm_form.op[3];
  assign is_mult = dispatch_word.reg_form.op == issue_pkg::op_mul ||
                   dispatch_word.reg_form.op == issue_pkg::op_muli;
  assign imm_value = {{(issue_pkg::data_width - issue_pkg::imm_width)
                       {dispatch_word.imm_form.imm[issue_pkg::imm_width-1]}},
                      dispatch_word.imm_form.imm};
  assign op2_ready = is_imm || src2_ready;
  assign op2_value = is_imm ? imm_value : src2_value;

  // Lowest free entry of the matching type
  always_comb begin
    found = 1'b0;
    free_idx = '0;
    for (int i = issue_pkg::num_entries - 1; i >= 0; i--) begin
      if (!busy[i] && issue_pkg::entry_unit[i] == is_mult) begin
        found = 1'b1;
        free_idx = issue_pkg::entry_idx_width'(i);
      end
    end
  end

  assign accept = dispatch_req && !dispatch_ack && found && !rollback_en;
  assign alloc_en = accept;
  assign alloc_tag = dispatch_word.reg_form.dest;

  always_comb begin
    for (int i = 0; i < issue_pkg::num_entries; i++) begin
      hit1[i] = cdb_valid && cdb_tag != issue_pkg::zero_tag && tag1_q[i] == cdb_tag;
      hit2[i] = cdb_valid && cdb_tag != issue_pkg::zero_tag && tag2_q[i] == cdb_tag;
      ready1[i] = ready1_q[i] || hit1[i];  // Woken in the same cycle
      ready2[i] = ready2_q[i] || hit2[i];
      rob_diff[i] = rob_q[i] - rollback_rob;  // Wraps modulo 16
      rolled[i] = rollback_en && busy[i] && rob_diff[i] <= rollback_count;
      issue_valid[i] = busy[i] && ready1[i] && ready2[i] && unit_ready[i] && !rolled[i];
      issue_op[i] = op_q[i];
      issue_a[i] = ready1_q[i] ? value1_q[i] : cdb_value;
      issue_b[i] = ready2_q[i] ? value2_q[i] : cdb_value;
      issue_tag[i] = dest_q[i];
      issue_rob[i] = rob_q[i];
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      dispatch_ack <= 1'b0;
      busy <= '0;
      ready1_q <= '0;
      ready2_q <= '0;
    end else begin
      if (accept) begin
        dispatch_ack <= 1'b1;
      end else if (!dispatch_req) begin
        dispatch_ack <= 1'b0;  // Four-phase return to idle
      end
      ready1_q <= ready1;
      ready2_q <= ready2;
      for (int i = 0; i < issue_pkg::num_entries; i++) begin
        if (rolled[i] || issue_valid[i]) begin
          busy[i] <= 1'b0;
        end
      end
      if (accept) begin
        busy[free_idx] <= 1'b1;
        ready1_q[free_idx] <= src1_ready;
        ready2_q[free_idx] <= op2_ready;
      end
    end
  end

  always_ff @(posedge clock) begin
    for (int i = 0; i < issue_pkg::num_entries; i++) begin
      if (hit1[i] && !ready1_q[i]) begin
        value1_q[i] <= cdb_value;  // Capture broadcast result
      end
      if (hit2[i] && !ready2_q[i]) begin
        value2_q[i] <= cdb_value;
      end
    end
    if (accept) begin
      op_q[free_idx] <= dispatch_word.reg_form.op;
      dest_q[free_idx] <= dispatch_word.reg_form.dest;
      rob_q[free_idx] <= dispatch_rob;
      tag1_q[free_idx] <= dispatch_word.reg_form.src1;
      tag2_q[free_idx] <= is_imm ? issue_pkg::zero_tag : dispatch_word.reg_form.src2;
      value1_q[free_idx] <= src1_value;
      value2_q[free_idx] <= op2_value;
    end
  end

endmodule

/* verilog/phys_reg_file.sv */
`timescale 1ns/1ps

module phys_reg_file (
  input  logic clock,
  input  logic reset,
  input  logic [issue_pkg::tag_width-1:0] src1_tag,
  input  logic [issue_pkg::tag_width-1:0] src2_tag,
  input  logic alloc_en,
  input  logic [issue_pkg::tag_width-1:0] alloc_tag,
  input  logic cdb_valid,
  input  logic [issue_pkg::tag_width-1:0] cdb_tag,
  input  logic [issue_pkg::data_width-1:0] cdb_value,
  output logic src1_ready,
  output logic [issue_pkg::data_width-1:0] src1_value,
  output logic src2_ready,
  output logic [issue_pkg::data_width-1:0] src2_value
);

  logic [issue_pkg::data_width-1:0] values [issue_pkg::num_regs];
  logic [issue_pkg::num_regs-1:0] ready;

  // Ready bit and value with a same-cycle bus write forwarded
  function automatic logic [issue_pkg::data_width:0] read_port(
    input logic [issue_pkg::tag_width-1:0] tag
  );
    if (tag == issue_pkg::zero_tag) begin
      return {1'b1, {issue_pkg::data_width{1'b0}}};
    end else if (cdb_valid && cdb_tag == tag) begin
      return {1'b1, cdb_value};
    end
    return {ready[tag], values[tag]};
  endfunction

  assign {src1_ready, src1_value} = read_port(src1_tag);
  assign {src2_ready, src2_value} = read_port(src2_tag);

  always_ff @(posedge clock) begin
    if (reset) begin
      ready <= '1;
      for (int r = 0; r < issue_pkg::num_regs; r++) begin
        values[r] <= '0;
      end
    end else begin
      if (cdb_valid && cdb_tag != issue_pkg::zero_tag) begin
        values[cdb_tag] <= cdb_value;
        ready[cdb_tag] <= 1'b1;
      end
      if (alloc_en && alloc_tag != issue_pkg::zero_tag) begin
        ready[alloc_tag] <= 1'b0;  // Busy until its result is broadcast
      end
    end
  end

endmodule

/* verilog/alu_unit.sv */
`timescale 1ns/1ps

module alu_unit (
  input  logic clock,
  input  logic reset,
  input  logic issue_valid,
  input  logic [issue_pkg::op_width-1:0] op,
  input  logic [issue_pkg::data_width-1:0] operand_a,
  input  logic [issue_pkg::data_width-1:0] operand_b,
  input  logic [issue_pkg::tag_width-1:0] issue_tag,
  input  logic [issue_pkg::rob_width-1:0] issue_rob,
  input  logic done_grant,
  output logic unit_ready,
  output logic done_valid,
  output logic [issue_pkg::tag_width-1:0] done_tag,
  output logic [issue_pkg::data_width-1:0] done_value,
  output logic [issue_pkg::rob_width-1:0] done_rob
);

  logic [issue_pkg::data_width-1:0] result;
  logic load;

  assign unit_ready = !done_valid || done_grant;  // Empty or leaving this cycle
  assign load = issue_valid && unit_ready;

  always_comb begin
    case (op)
      issue_pkg::op_sub: result = operand_a - operand_b;
      issue_pkg::op_and: result = operand_a & operand_b;
      issue_pkg::op_xor, issue_pkg::op_xori: result = operand_a ^ operand_b;
      default: result = operand_a + operand_b;  // add and addi
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      done_valid <= 1'b0;
    end else if (load) begin
      done_valid <= 1'b1;
    end else if (done_grant) begin
      done_valid <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (load) begin
      done_tag <= issue_tag;
      done_value <= result;
      done_rob <= issue_rob;
    end
  end

endmodule

/* verilog/mult_unit.sv */
`timescale 1ns/1ps

module mult_unit (
  input  logic clock,
  input  logic reset,
  input  logic issue_valid,
  input  logic [issue_pkg::op_width-1:0] op,
  input  logic [issue_pkg::data_width-1:0] operand_a,
  input  logic [issue_pkg::data_width-1:0] operand_b,
  input  logic [issue_pkg::tag_width-1:0] issue_tag,
  input  logic [issue_pkg::rob_width-1:0] issue_rob,
  input  logic done_grant,
  output logic unit_ready,
  output logic done_valid,
  output logic [issue_pkg::tag_width-1:0] done_tag,
  output logic [issue_pkg::data_width-1:0] done_value,
  output logic [issue_pkg::rob_width-1:0] done_rob
);

  localparam int hw = issue_pkg::half_width;

  logic advance;
  logic s1_valid;
  logic [issue_pkg::tag_width-1:0] s1_tag;
  logic [issue_pkg::rob_width-1:0] s1_rob;
  logic [issue_pkg::data_width-1:0] s1_a;
  logic [issue_pkg::data_width-1:0] s1_b;
  logic s2_valid;
  logic [issue_pkg::tag_width-1:0] s2_tag;
  logic [issue_pkg::rob_width-1:0] s2_rob;
  logic [issue_pkg::data_width-1:0] s2_low;  // Low halves product
  logic [hw-1:0] s2_cross;  // Cross products keep only the low half

  assign advance = !done_valid || done_grant;  // Whole pipe stalls with the last stage
  assign unit_ready = advance;

  always_ff @(posedge clock) begin
    if (reset) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
      done_valid <= 1'b0;
    end else if (advance) begin
      s1_valid <= issue_valid && (op == issue_pkg::op_mul || op == issue_pkg::op_muli);
      s2_valid <= s1_valid;
      done_valid <= s2_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (advance) begin
      s1_tag <= issue_tag;
      s1_rob <= issue_rob;
      s1_a <= operand_a;
      s1_b <= operand_b;
      s2_tag <= s1_tag;
      s2_rob <= s1_rob;
      s2_low <= s1_a[hw-1:0] * s1_b[hw-1:0];
      s2_cross <= s1_a[hw-1:0] * s1_b[2*hw-1:hw] + s1_a[2*hw-1:hw] * s1_b[hw-1:0];
      done_tag <= s2_tag;
      done_rob <= s2_rob;
      done_value <= s2_low + {s2_cross, {hw{1'b0}}};
    end
  end

endmodule

/* verilog/cdb_arbiter.sv */
`timescale 1ns/1ps

module cdb_arbiter (
  input  logic [issue_pkg::num_entries-1:0] done_valid,
  input  logic [issue_pkg::num_entries-1:0][issue_pkg::tag_width-1:0] done_tag,
  input  logic [issue_pkg::num_entries-1:0][issue_pkg::data_width-1:0] done_value,
  input  logic [issue_pkg::num_entries-1:0][issue_pkg::rob_width-1:0] done_rob,
  output logic [issue_pkg::num_entries-1:0] done_grant,
  output logic cdb_valid,
  output logic [issue_pkg::tag_width-1:0] cdb_tag,
  output logic [issue_pkg::data_width-1:0] cdb_value,
  output logic [issue_pkg::rob_width-1:0] cdb_rob
);

  logic [issue_pkg::entry_idx_width-1:0] sel;

  // Multiply units first, then ALUs in entry order
  always_comb begin
    sel = '0;
    for (int i = issue_pkg::num_entries - 1; i >= 0; i--) begin
      if (done_valid[i] && issue_pkg::entry_unit[i] == issue_pkg::unit_alu) begin
        sel = issue_pkg::entry_idx_width'(i);
      end
    end
    for (int i = issue_pkg::num_entries - 1; i >= 0; i--) begin
      if (done_valid[i] && issue_pkg::entry_unit[i] == issue_pkg::unit_mult) begin
        sel = issue_pkg::entry_idx_width'(i);
      end
    end
  end

  assign cdb_valid = |done_valid;
  assign done_grant = cdb_valid ? issue_pkg::num_entries'(1) << sel : '0;
  assign cdb_tag = done_tag[sel];
  assign cdb_value = done_value[sel];
  assign cdb_rob = done_rob[sel];

endmodule

/* verilog/issue_core.sv */
`timescale 1ns/1ps

module issue_core (
  input  logic clock,
  input  logic reset,
  input  logic dispatch_req,
  input  issue_pkg::dispatch_word_u dispatch_word,
  input  logic [issue_pkg::rob_width-1:0] dispatch_rob,
  input  logic rollback_en,
  input  logic [issue_pkg::rob_width-1:0] rollback_rob,
  input  logic [issue_pkg::rob_width-1:0] rollback_count,
  output logic dispatch_ack,
  output logic cdb_valid,
  output logic [issue_pkg::tag_width-1:0] cdb_tag,
  output logic [issue_pkg::data_width-1:0] cdb_value,
  output logic [issue_pkg::rob_width-1:0] cdb_rob
);

  logic [issue_pkg::tag_width-1:0] src1_tag;
  logic [issue_pkg::tag_width-1:0] src2_tag;
  logic src1_ready;
  logic [issue_pkg::data_width-1:0] src1_value;
  logic src2_ready;
  logic [issue_pkg::data_width-1:0] src2_value;
  logic alloc_en;
  logic [issue_pkg::tag_width-1:0] alloc_tag;
  logic [issue_pkg::num_entries-1:0] unit_ready;
  logic [issue_pkg::num_entries-1:0] issue_valid;
  logic [issue_pkg::num_entries-1:0][issue_pkg::op_width-1:0] issue_op;
  logic [issue_pkg::num_entries-1:0][issue_pkg::data_width-1:0] issue_a;
  logic [issue_pkg::num_entries-1:0][issue_pkg::data_width-1:0] issue_b;
  logic [issue_pkg::num_entries-1:0][issue_pkg::tag_width-1:0] issue_tag;
  logic [issue_pkg::num_entries-1:0][issue_pkg::rob_width-1:0] issue_rob;
  logic [issue_pkg::num_entries-1:0] done_valid;
  logic [issue_pkg::num_entries-1:0][issue_pkg::tag_width-1:0] done_tag;
  logic [issue_pkg::num_entries-1:0][issue_pkg::data_width-1:0] done_value;
  logic [issue_pkg::num_entries-1:0][issue_pkg::rob_width-1:0] done_rob;
  logic [issue_pkg::num_entries-1:0] done_grant;

  reservation_station reservation_station_i (.*);

  phys_reg_file phys_reg_file_i (.*);

  // Entries 0 and 1 feed the ALUs, entry 2 the multiplier
  alu_unit alu_0_i (
    .clock(clock), .reset(reset), .issue_valid(issue_valid[0]), .op(issue_op[0]),
    .operand_a(issue_a[0]), .operand_b(issue_b[0]), .issue_tag(issue_tag[0]),
    .issue_rob(issue_rob[0]), .done_grant(done_grant[0]), .unit_ready(unit_ready[0]),
    .done_valid(done_valid[0]), .done_tag(done_tag[0]), .done_value(done_value[0]),
    .done_rob(done_rob[0])
  );

  alu_unit alu_1_i (
    .clock(clock), .reset(reset), .issue_valid(issue_valid[1]), .op(issue_op[1]),
    .operand_a(issue_a[1]), .operand_b(issue_b[1]), .issue_tag(issue_tag[1]),
    .issue_rob(issue_rob[1]), .done_grant(done_grant[1]), .unit_ready(unit_ready[1]),
    .done_valid(done_valid[1]), .done_tag(done_tag[1]), .done_value(done_value[1]),
    .done_rob(done_rob[1])
  );

  mult_unit mult_i (
    .clock(clock), .reset(reset), .issue_valid(issue_valid[2]), .op(issue_op[2]),
    .operand_a(issue_a[2]), .operand_b(issue_b[2]), .issue_tag(issue_tag[2]),
    .issue_rob(issue_rob[2]), .done_grant(done_grant[2]), .unit_ready(unit_ready[2]),
    .done_valid(done_valid[2]), .done_tag(done_tag[2]), .done_value(done_value[2]),
    .done_rob(done_rob[2])
  );

  cdb_arbiter cdb_arbiter_i (.*);

endmodule

/* testbench/issue_core_properties.sv */
`timescale 1ns/1ps

module reservation_station_properties (
  input logic clock,
  input logic reset,
  input logic dispatch_req,
  input logic dispatch_ack,
  input logic alloc_en,
  input logic [issue_pkg::tag_width-1:0] alloc_tag,
  input logic cdb_valid,
  input logic [issue_pkg::tag_width-1:0] cdb_tag,
  input logic [issue_pkg::num_entries-1:0] issue_valid,
  input logic [issue_pkg::num_entries-1:0][issue_pkg::tag_width-1:0] tag1_q,
  input logic [issue_pkg::num_entries-1:0][issue_pkg::tag_width-1:0] tag2_q
);

  int failures = 0;  // Assertion failure count
  logic [issue_pkg::num_regs-1:0] written;  // Register already holds its result

  always_ff @(posedge clock) begin
    if (reset) begin
      written <= '1;
    end else begin
      if (cdb_valid && cdb_tag != issue_pkg::zero_tag) begin
        written[cdb_tag] <= 1'b1;
      end
      if (alloc_en && alloc_tag != issue_pkg::zero_tag) begin
        written[alloc_tag] <= 1'b0;
      end
    end
  end

  ack_needs_req: assert property (@(posedge clock) disable iff (reset)
    $rose(dispatch_ack) |-> $past(dispatch_req))
    else begin
      $error("dispatch_ack rose without dispatch_req");
      failures++;
    end

  ack_held: assert property (@(posedge clock) disable iff (reset)
    dispatch_ack && dispatch_req |=> dispatch_ack)
    else begin
      $error("dispatch_ack dropped while dispatch_req was still high");
      failures++;
    end

  no_zero_broadcast: assert property (@(posedge clock) disable iff (reset)
    cdb_valid |-> cdb_tag != issue_pkg::zero_tag)
    else begin
      $error("common data bus broadcast on the zero tag");
      failures++;
    end

  for (genvar i = 0; i < issue_pkg::num_entries; i++) begin : g_entry
    ready_at_issue: assert property (@(posedge clock) disable iff (reset)
      issue_valid[i] |->
        (written[tag1_q[i]] || (cdb_valid && cdb_tag == tag1_q[i])) &&
        (written[tag2_q[i]] || (cdb_valid && cdb_tag == tag2_q[i])))
      else begin
        $error("entry %0d issued with an operand not ready", i);
        failures++;
      end
  end

endmodule

bind reservation_station reservation_station_properties properties_i (
  .clock(clock), .reset(reset), .dispatch_req(dispatch_req), .dispatch_ack(dispatch_ack),
  .alloc_en(alloc_en), .alloc_tag(alloc_tag),
  .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .issue_valid(issue_valid),
  .tag1_q(tag1_q), .tag2_q(tag2_q)
);

/* testbench/issue_core_tb.sv */
`timescale 1ns/1ps

module issue_core_tb;

  logic clock;
  logic reset;
  logic dispatch_req;
  issue_pkg::dispatch_word_u dispatch_word;
  logic [issue_pkg::rob_width-1:0] dispatch_rob;
  logic rollback_en;
  logic [issue_pkg::rob_width-1:0] rollback_rob;
  logic [issue_pkg::rob_width-1:0] rollback_count;
  logic dispatch_ack;
  logic cdb_valid;
  logic [issue_pkg::tag_width-1:0] cdb_tag;
  logic [issue_pkg::data_width-1:0] cdb_value;
  logic [issue_pkg::rob_width-1:0] cdb_rob;

  logic [issue_pkg::data_width-1:0] shadow [issue_pkg::num_regs];  // Final value per tag
  logic [issue_pkg::rob_width-1:0] owner_rob [issue_pkg::num_regs];
  logic [issue_pkg::tag_width-1:0] exp_tag [16];  // Indexed by reorder buffer index
  logic [issue_pkg::data_width-1:0] exp_value [16];
  logic [15:0] pending;
  logic [15:0] rolled_back;
  logic [issue_pkg::tag_width-1:0] next_tag;
  logic [issue_pkg::rob_width-1:0] next_rob;
  logic [issue_pkg::tag_width-1:0] last_tag;
  logic [issue_pkg::rob_width-1:0] last_rob;
  int dispatch_count;
  int ack_wait;  // Falling edges from request to ack
  int cycles;
  int seed;
  int tag_errors;
  int value_errors;
  int rob_errors;
  int other_errors;

  issue_core issue_core_i (.*);

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  function automatic logic [issue_pkg::data_width-1:0] ref_result(
    input issue_pkg::dispatch_word_u w
  );
    logic [issue_pkg::data_width-1:0] a;
    logic [issue_pkg::data_width-1:0] b;
    a = shadow[w.reg_form.src1];
    if (w.imm_form.op[3]) begin
      b = {{16{w.imm_form.imm[15]}}, w.imm_form.imm};  // Sign-extended immediate
    end else begin
      b = shadow[w.reg_form.src2];
    end
    case (w.reg_form.op)
      issue_pkg::op_add, issue_pkg::op_addi: return a + b;
      issue_pkg::op_sub: return a - b;
      issue_pkg::op_and: return a & b;
      issue_pkg::op_xor, issue_pkg::op_xori: return a ^ b;
      issue_pkg::op_mul, issue_pkg::op_muli: return a * b;  // Low 32 bits
      default: return 'x;
    endcase
  endfunction

  function automatic logic [issue_pkg::op_width-1:0] pick_op(input logic [2:0] k);
    case (k)
      3'd0: return issue_pkg::op_add;
      3'd1: return issue_pkg::op_sub;
      3'd2: return issue_pkg::op_and;
      3'd3: return issue_pkg::op_xor;
      3'd4: return issue_pkg::op_mul;
      3'd5: return issue_pkg::op_addi;
      3'd6: return issue_pkg::op_xori;
      default: return issue_pkg::op_muli;
    endcase
  endfunction

  task automatic check_tag(input string name, input logic [issue_pkg::tag_width-1:0] got,
                           input logic [issue_pkg::tag_width-1:0] expected);
    if (got !== expected) begin
      tag_errors++;
      $display("ERR %s got %h expected %h", name, got, expected);
    end
  endtask

  task automatic check_value(input string name, input logic [issue_pkg::data_width-1:0] got,
                             input logic [issue_pkg::data_width-1:0] expected);
    if (got !== expected) begin
      value_errors++;
      $display("ERR %s got %h expected %h", name, got, expected);
    end
  endtask

  task automatic check_rob(input string name, input logic [issue_pkg::rob_width-1:0] got,
                           input logic [issue_pkg::rob_width-1:0] expected);
    if (got !== expected) begin
      rob_errors++;
      $display("ERR %s got %h expected %h", name, got, expected);
    end
  endtask

  // Plays the renamer with a fresh dest tag and index in a four-phase request
  task automatic dispatch(input logic [issue_pkg::op_width-1:0] op,
                          input logic [issue_pkg::tag_width-1:0] src1,
                          input logic [issue_pkg::imm_width-1:0] field);
    issue_pkg::dispatch_word_u w;
    w = '0;
    if (op[3]) begin
      w.imm_form.op = op;
      w.imm_form.dest = next_tag;
      w.imm_form.src1 = src1;
      w.imm_form.imm = field;
    end else begin
      w.reg_form.op = op;
      w.reg_form.dest = next_tag;
      w.reg_form.src1 = src1;
      w.reg_form.src2 = field[issue_pkg::tag_width-1:0];
    end
    while (dispatch_ack) @(negedge clock);
    exp_tag[next_rob] = next_tag;
    exp_value[next_rob] = ref_result(w);
    pending[next_rob] = 1'b1;
    rolled_back[next_rob] = 1'b0;
    owner_rob[next_tag] = next_rob;
    shadow[next_tag] = exp_value[next_rob];
    last_tag = next_tag;
    last_rob = next_rob;
    next_tag++;
    next_rob++;
    dispatch_count++;
    dispatch_word = w;
    dispatch_rob = last_rob;
    dispatch_req = 1'b1;
    ack_wait = 0;
    do begin
      @(negedge clock);
      ack_wait++;
    end while (!dispatch_ack);
    dispatch_req = 1'b0;
  endtask

  task automatic rollback(input logic [issue_pkg::rob_width-1:0] first,
                          input logic [issue_pkg::rob_width-1:0] count);
    logic [issue_pkg::rob_width-1:0] idx;
    rollback_en = 1'b1;
    rollback_rob = first;
    rollback_count = count;
    for (int k = 0; k <= int'(count); k++) begin
      idx = first + k[issue_pkg::rob_width-1:0];  // Window wraps modulo 16
      if (pending[idx]) begin
        pending[idx] = 1'b0;
        rolled_back[idx] = 1'b1;
      end
    end
    @(negedge clock);
    rollback_en = 1'b0;
  endtask

  task automatic wait_idle();
    while (pending != '0) @(negedge clock);
  endtask

  always @(posedge clock) begin
    if (!reset && cdb_valid) begin
      if (rolled_back[cdb_rob]) begin
        other_errors++;
        $display("Result for index %0d appeared although it was rolled back", cdb_rob);
      end else if (!pending[cdb_rob]) begin
        other_errors++;
        $display("Result for index %0d appeared although it was never dispatched", cdb_rob);
      end else begin
        check_tag("cdb_tag", cdb_tag, exp_tag[cdb_rob]);
        check_value("cdb_value", cdb_value, exp_value[cdb_rob]);
        check_rob("cdb_rob", cdb_rob, owner_rob[cdb_tag]);
        pending[cdb_rob] = 1'b0;
      end
    end
  end

  // Limit grows with every dispatched instruction
  initial begin
    cycles = 0;
    while (cycles <= 40 * dispatch_count + 200) begin
      @(posedge clock);
      cycles++;
    end
    $display("Timeout after %0d cycles with instructions still outstanding", cycles);
    $display("TESTS FAILED");
    $finish;
  end

  initial begin
    int r;
    logic [issue_pkg::op_width-1:0] op;
    logic [issue_pkg::tag_width-1:0] s1;
    logic [issue_pkg::tag_width-1:0] s2;
    logic [issue_pkg::tag_width-1:0] m1;
    logic [issue_pkg::tag_width-1:0] blocked;
    logic [issue_pkg::rob_width-1:0] first_rob;
    int total;
    seed = 4263;
    reset = 1'b1;
    dispatch_req = 1'b0;
    dispatch_word = '0;
    dispatch_rob = '0;
    rollback_en = 1'b0;
    rollback_rob = '0;
    rollback_count = '0;
    pending = '0;
    rolled_back = '0;
    next_tag = 6'd1;  // Tag 0 is never a destination
    next_rob = '0;
    dispatch_count = 0;
    tag_errors = 0;
    value_errors = 0;
    rob_errors = 0;
    other_errors = 0;
    for (int t = 0; t < issue_pkg::num_regs; t++) begin
      shadow[t] = '0;
      owner_rob[t] = '0;
    end
    repeat (16) @(negedge clock);
    reset = 1'b0;

    // Immediate forms seed registers 1 to 8
    for (int n = 0; n < 6; n++) begin
      r = $random(seed);
      dispatch(issue_pkg::op_addi, issue_pkg::zero_tag, r[15:0]);
    end
    dispatch(issue_pkg::op_addi, 6'd1, 16'h8001);
    dispatch(issue_pkg::op_xori, 6'd2, 16'hff00);
    wait_idle();

    dispatch(issue_pkg::op_add, 6'd1, 16'd2);  // Register form on ready tags
    dispatch(issue_pkg::op_sub, 6'd3, 16'd4);
    dispatch(issue_pkg::op_and, 6'd5, 16'd6);
    dispatch(issue_pkg::op_xor, 6'd7, 16'd8);
    wait_idle();

    // Dependent chain with each source still in flight
    dispatch(issue_pkg::op_mul, 6'd3, 16'd4);
    dispatch(issue_pkg::op_add, last_tag, 16'd5);
    dispatch(issue_pkg::op_sub, last_tag, 16'd2);
    dispatch(issue_pkg::op_xori, last_tag, 16'h1234);
    dispatch(issue_pkg::op_muli, last_tag, 16'hfffd);
    wait_idle();

    for (int n = 0; n < 12; n++) begin
      r = $random(seed);
      op = pick_op(r[2:0]);
      s1 = issue_pkg::tag_width'($unsigned($random(seed)) % next_tag);
      s2 = issue_pkg::tag_width'($unsigned($random(seed)) % next_tag);
      r = $random(seed);
      dispatch(op, s1, op[3] ? r[15:0] : {10'b0, s2});
    end
    wait_idle();

    // Each add finishes in the cycle its multiply does and waits for the bus
    for (int n = 0; n < 3; n++) begin
      dispatch(issue_pkg::op_mul, issue_pkg::tag_width'(n + 1), 16'd2);
      dispatch(issue_pkg::op_add, 6'd3, 16'd4);
    end
    wait_idle();

    // Third multiply finds the only multiply entry busy
    dispatch(issue_pkg::op_mul, 6'd3, 16'd5);
    m1 = last_tag;
    dispatch(issue_pkg::op_mul, m1, 16'd6);
    dispatch(issue_pkg::op_muli, last_tag, 16'h0007);
    if (ack_wait < 2) begin
      other_errors++;
      $display("Dispatch ack for a multiply with no free entry came without delay");
    end
    dispatch(issue_pkg::op_add, last_tag, {10'b0, m1});
    wait_idle();

    // Cleared before it issues, so its tag never turns ready
    dispatch(issue_pkg::op_add, 6'd4, 16'd5);
    blocked = last_tag;
    rollback(last_rob, 4'd0);
    dispatch(issue_pkg::op_add, blocked, 16'd3);
    first_rob = last_rob;
    dispatch(issue_pkg::op_mul, blocked, 16'd4);
    dispatch(issue_pkg::op_xor, 6'd6, 16'd7);
    rollback(first_rob, 4'd1);
    dispatch(issue_pkg::op_muli, 6'd8, 16'h0011);
    wait_idle();
    repeat (20) @(negedge clock);

    total = tag_errors + value_errors + rob_errors + other_errors +
            issue_core_i.reservation_station_i.properties_i.failures;
    $display("Errors: tag %0d, value %0d, index %0d, other %0d, assertion %0d",
             tag_errors, value_errors, rob_errors, other_errors,
             issue_core_i.reservation_station_i.properties_i.failures);
    if (total == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

/* list.f */
verilog/issue_pkg.sv
verilog/reservation_station.sv
verilog/phys_reg_file.sv
verilog/alu_unit.sv
verilog/mult_unit.sv
verilog/cdb_arbiter.sv
verilog/issue_core.sv
testbench/issue_core_properties.sv
testbench/issue_core_tb.sv
